/* Makefile */
# Verilator build and run for the board control bus testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = tb_bus_int
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log

SOURCES = $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "TEST FAILED" $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/apb_pkg.sv */
/*
 * APB slave address type and bridge FSM states
 */
package apb_pkg;

   // Byte address, word index in bits 9:2
   typedef logic [9:0] apb_addr_t;

   // Bridge FSM
   // IDLE waits for setup, ACCESS issues the strobe, DONE raises PREADY
   typedef enum logic [1:0] {
      IDLE,
      ACCESS,
      DONE
   } apb_state_t;

endpackage

/* hw/apb_settings_bridge.sv */
/*
 * APB slave onto the shared settings and readback buses
 * One strobe per transfer, PREADY in the second access cycle
 */
`timescale 1ns/1ns

module apb_settings_bridge
   import bus_types_pkg::*;
   import apb_pkg::*;
(
   input  logic           clk,
   input  logic           i_rst_n,
   // APB slave port
   input  logic           i_psel,
   input  logic           i_penable,
   input  logic           i_pwrite,
   input  apb_addr_t      i_paddr,
   input  set_data_t      i_pwdata,
   output set_data_t      o_prdata,
   output logic           o_pready,
   // Shared bus, one copy per register block
   settings_bus_if.bridge bus_ctrl,
   settings_bus_if.bridge bus_sfpp
);

   apb_state_t state;
   apb_state_t state_nxt;
   logic       acc_cyc;
   set_addr_t  bus_addr;
   set_data_t  rb_word;

   // ----------------------------------------------------------------------
   // Transfer FSM
   // ----------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         // Setup cycle seen
         IDLE:    if (i_psel && !i_penable) state_nxt = ACCESS;
         // First access cycle, strobe goes out here
         ACCESS:  if (i_psel && i_penable) state_nxt = DONE;
         // PREADY cycle, host releases afterwards
         DONE:    state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Only the first access cycle counts, PENABLE stays up one more
   assign acc_cyc  = (state == ACCESS) && i_psel && i_penable;
   assign o_pready = (state == DONE);

   // Word address from the byte address
   assign bus_addr = i_paddr[9:2];

   // ----------------------------------------------------------------------
   // Bus drive, same values to both blocks
   // ----------------------------------------------------------------------
   assign bus_ctrl.set_stb   = acc_cyc && i_pwrite;
   assign bus_ctrl.set_addr  = bus_addr;
   assign bus_ctrl.set_data  = i_pwdata;
   assign bus_ctrl.rb_rd_stb = acc_cyc && !i_pwrite;
   assign bus_ctrl.rb_addr   = bus_addr;

   assign bus_sfpp.set_stb   = acc_cyc && i_pwrite;
   assign bus_sfpp.set_addr  = bus_addr;
   assign bus_sfpp.set_data  = i_pwdata;
   assign bus_sfpp.rb_rd_stb = acc_cyc && !i_pwrite;
   assign bus_sfpp.rb_addr   = bus_addr;

   // Blocks zero what they do not own, so a plain OR merges them
   assign rb_word = bus_ctrl.rb_data | bus_sfpp.rb_data;

   // Read data taken at the strobe edge
   // Held through DONE while the host samples it
   always_ff @(posedge clk) begin
      if (acc_cyc && !i_pwrite) begin
         o_prdata <= rb_word;
      end
   end

endmodule

/* hw/bus_int_consts.svh */
/*
 * Bus interface constants: settings and readback addresses,
 * compatibility number, SFP+ cage count and register reset values
 */
`ifndef BUS_INT_CONSTS_SVH
`define BUS_INT_CONSTS_SVH

// ----------------------------------------------------------------------
// Settings bus addresses
// ----------------------------------------------------------------------
`define SR_LEDS          8'd0
`define SR_SW_RST        8'd1
`define SR_CLOCK_CTRL    8'd2
// One rate-select control word per SFP+ cage
`define SR_SFPP_CTRL0    8'd8
`define SR_SFPP_CTRL1    8'd9

// ----------------------------------------------------------------------
// Readback bus addresses
// ----------------------------------------------------------------------
`define RB_COUNTER       8'd0
`define RB_CLK_STATUS    8'd3
`define RB_COMPAT_NUM    8'd6
// Pin and PHY status, one word per cage
`define RB_SFPP_STATUS0  8'd8
`define RB_SFPP_STATUS1  8'd9

// ----------------------------------------------------------------------
// Identity and reset values
// ----------------------------------------------------------------------
// Major in the upper half of the compat word
`define COMPAT_MAJOR     16'h000A
`define COMPAT_MINOR     16'h0000

// Bit 6 set, GPSDO reference enabled out of reset
`define CLOCK_CTRL_RESET 7'b1000000

// Number of SFP+ cages on the board
`define NUM_SFPP         2

`endif

/* hw/bus_int_top.sv */
/*
 * Board control bus top: APB bridge, control registers, SFP+ status
 */
`timescale 1ns/1ns
`include "bus_int_consts.svh"

module bus_int_top
   import bus_types_pkg::*;
   import apb_pkg::*;
(
   input  logic                         clk,
   input  logic                         i_rst_n,
   // APB slave
   input  logic                         i_psel,
   input  logic                         i_penable,
   input  logic                         i_pwrite,
   input  apb_addr_t                    i_paddr,
   input  set_data_t                    i_pwdata,
   output set_data_t                    o_prdata,
   output logic                         o_pready,
   // Board control pins
   input  logic        [4:0]            i_clock_status,
   output logic        [7:0]            o_leds,
   output logic        [3:0]            o_sw_rst,
   output logic        [6:0]            o_clock_control,
   output logic        [`NUM_SFPP-1:0][1:0] o_sfpp_rs_oe,
   // SFP+ cage status
   input  sfpp_pins_t  [`NUM_SFPP-1:0]  i_sfpp_pins,
   input  phy_status_t [`NUM_SFPP-1:0]  i_phy_status
);

   // One bus copy per register block, same master
   settings_bus_if bus_ctrl ();
   settings_bus_if bus_sfpp ();

   apb_settings_bridge u_bridge (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_psel    (i_psel),
      .i_penable (i_penable),
      .i_pwrite  (i_pwrite),
      .i_paddr   (i_paddr),
      .i_pwdata  (i_pwdata),
      .o_prdata  (o_prdata),
      .o_pready  (o_pready),
      .bus_ctrl  (bus_ctrl.bridge),
      .bus_sfpp  (bus_sfpp.bridge)
   );

   ctrl_regs u_ctrl (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .bus             (bus_ctrl.block),
      .i_clock_status  (i_clock_status),
      .o_leds          (o_leds),
      .o_sw_rst        (o_sw_rst),
      .o_clock_control (o_clock_control),
      .o_sfpp_rs_oe    (o_sfpp_rs_oe)
   );

   sfpp_status u_sfpp (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .bus          (bus_sfpp.block),
      .i_sfpp_pins  (i_sfpp_pins),
      .i_phy_status (i_phy_status)
   );

endmodule

/* hw/bus_types_pkg.sv */
/*
 * Types for the settings and readback buses
 * and the SFP+ status fields
 */
package bus_types_pkg;

   // Settings or readback register address
   typedef logic [7:0]  set_addr_t;

   // Settings write data and readback word
   typedef logic [31:0] set_data_t;

   // SFP+ cage pins
   // MSB to LSB: module absent, tx fault, rx loss of signal
   typedef logic [2:0]  sfpp_pins_t;

   // PHY status word, all bits asynchronous to clk
   typedef logic [15:0] phy_status_t;

endpackage

/* hw/ctrl_regs.sv */
/*
 * Control settings registers plus identity, cycle counter
 * and clock status readbacks
 */
`timescale 1ns/1ns
`include "bus_int_consts.svh"

module ctrl_regs
   import bus_types_pkg::*;
(
   input  logic                      clk,
   input  logic                      i_rst_n,
   settings_bus_if.block             bus,
   input  logic [4:0]                i_clock_status,
   output logic [7:0]                o_leds,
   output logic [3:0]                o_sw_rst,
   output logic [6:0]                o_clock_control,
   // Set bit pulls the RS pin low
   output logic [`NUM_SFPP-1:0][1:0] o_sfpp_rs_oe
);

   // Rate-select control address per cage
   localparam set_addr_t SFPP_CTRL_ADDR [`NUM_SFPP] = '{`SR_SFPP_CTRL0, `SR_SFPP_CTRL1};

   set_data_t counter;

   // ----------------------------------------------------------------------
   // Settings registers
   // ----------------------------------------------------------------------
   // Software reset bits
   //   0: PHY, 1: radio clock domain, 2: radio clock PLL, 3: spare
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_leds          <= '0;
         o_sw_rst        <= '0;
         o_clock_control <= `CLOCK_CTRL_RESET;
         o_sfpp_rs_oe    <= '0;
      end else if (bus.set_stb) begin
         case (bus.set_addr)
            `SR_LEDS:       o_leds          <= bus.set_data[7:0];
            `SR_SW_RST:     o_sw_rst        <= bus.set_data[3:0];
            `SR_CLOCK_CTRL: o_clock_control <= bus.set_data[6:0];
            default: ;
         endcase
         // RS0 in bit 0, RS1 in bit 1
         for (int p = 0; p < `NUM_SFPP; p++) begin
            if (bus.set_addr == SFPP_CTRL_ADDR[p]) begin
               o_sfpp_rs_oe[p] <= bus.set_data[1:0];
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // Free-running cycle counter
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         counter <= '0;
      end else begin
         counter <= counter + 32'd1;
      end
   end

   // ----------------------------------------------------------------------
   // Readback mux
   // ----------------------------------------------------------------------
   // Anything not listed reads as zero, sfpp_status answers its own
   always_comb begin
      case (bus.rb_addr)
         `RB_COMPAT_NUM: bus.rb_data = {`COMPAT_MAJOR, `COMPAT_MINOR};
         `RB_COUNTER:    bus.rb_data = counter;
         // Raw clock status, already in clk domain
         `RB_CLK_STATUS: bus.rb_data = {27'b0, i_clock_status};
         default:        bus.rb_data = '0;
      endcase
   end

endmodule

/* hw/settings_bus_if.sv */
/*
 * Settings bus with its readback bus
 * Bridge is the master, a register block answers its own addresses
 */
`timescale 1ns/1ns

interface settings_bus_if
   import bus_types_pkg::*;
();

   // Write side
   logic      set_stb;
   set_addr_t set_addr;
   set_data_t set_data;

   // Read side, rb_data is combinational from rb_addr
   logic      rb_rd_stb;
   set_addr_t rb_addr;
   set_data_t rb_data;

   modport bridge (
      output set_stb, set_addr, set_data,
      output rb_rd_stb, rb_addr,
      input  rb_data
   );

   // Zero on rb_data for addresses the block does not own
   modport block (
      input  set_stb, set_addr, set_data,
      input  rb_rd_stb, rb_addr,
      output rb_data
   );

endinterface

/* hw/sfpp_status.sv */
/*
 * SFP+ pin and PHY status synchronizers
 * Sticky pin change flags, cleared by reading the status word
 */
`timescale 1ns/1ns
`include "bus_int_consts.svh"

module sfpp_status
   import bus_types_pkg::*;
(
   input  logic                         clk,
   input  logic                         i_rst_n,
   settings_bus_if.block                bus,
   input  sfpp_pins_t  [`NUM_SFPP-1:0]  i_sfpp_pins,
   input  phy_status_t [`NUM_SFPP-1:0]  i_phy_status
);

   // Status word address per cage
   localparam set_addr_t SFPP_STATUS_ADDR [`NUM_SFPP] = '{`RB_SFPP_STATUS0, `RB_SFPP_STATUS1};

   // Pin pipeline: two sync stages then a delayed copy
   sfpp_pins_t  [`NUM_SFPP-1:0] pin_meta;
   sfpp_pins_t  [`NUM_SFPP-1:0] pin_sync;
   sfpp_pins_t  [`NUM_SFPP-1:0] pin_dly;
   sfpp_pins_t  [`NUM_SFPP-1:0] chg_flag;
   phy_status_t [`NUM_SFPP-1:0] phy_meta;
   phy_status_t [`NUM_SFPP-1:0] phy_sync;
   logic        [`NUM_SFPP-1:0] rd_clr;

   // ----------------------------------------------------------------------
   // Synchronizers
   // ----------------------------------------------------------------------
   // Every bit asynchronous, each gets its own two flops
   // Pin value valid two cycles after a change
   always_ff @(posedge clk) begin
      for (int p = 0; p < `NUM_SFPP; p++) begin
         pin_meta[p] <= i_sfpp_pins[p];
         pin_sync[p] <= pin_meta[p];
         pin_dly[p]  <= pin_sync[p];
         phy_meta[p] <= i_phy_status[p];
         phy_sync[p] <= phy_meta[p];
      end
   end

   // ----------------------------------------------------------------------
   // Change flags
   // ----------------------------------------------------------------------
   // Read strobe to the cage's own status address
   always_comb begin
      for (int p = 0; p < `NUM_SFPP; p++) begin
         rd_clr[p] = bus.rb_rd_stb && (bus.rb_addr == SFPP_STATUS_ADDR[p]);
      end
   end

   // Edge between sync and delayed copy sets the flag
   // A change on the clearing edge still wins
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         chg_flag <= '0;
      end else begin
         for (int p = 0; p < `NUM_SFPP; p++) begin
            chg_flag[p] <= (rd_clr[p] ? 3'b000 : chg_flag[p]) | (pin_sync[p] ^ pin_dly[p]);
         end
      end
   end

   // ----------------------------------------------------------------------
   // Readback
   // ----------------------------------------------------------------------
   // PHY status, 10 zero bits, change flags, synced pins
   always_comb begin
      bus.rb_data = '0;
      for (int p = 0; p < `NUM_SFPP; p++) begin
         if (bus.rb_addr == SFPP_STATUS_ADDR[p]) begin
            bus.rb_data = {phy_sync[p], 10'b0, chg_flag[p], pin_sync[p]};
         end
      end
   end

   // Settings side is unused here
   // Flags are cleared only through the readback strobe

endmodule

/* sim.f */
+incdir+hw
hw/bus_types_pkg.sv
hw/apb_pkg.sv
hw/settings_bus_if.sv
hw/apb_settings_bridge.sv
hw/ctrl_regs.sv
hw/sfpp_status.sv
hw/bus_int_top.sv
test/bus_int_chk.sv
test/tb_bus_int.sv

/* test/bus_int_chk.sv */
/*
 * Bound checker for the APB handshake and clock control reset value
 */
`timescale 1ns/1ns
`include "bus_int_consts.svh"

module bus_int_chk (
   input logic       clk,
   input logic       i_rst_n,
   input logic       i_psel,
   input logic       i_penable,
   input logic       i_pready,
   input logic [6:0] i_clock_control
);

   // ----------------------------------------------------------------------
   // APB handshake
   // ----------------------------------------------------------------------
   // PREADY only right after an access cycle
   a_pready_after_access: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      i_pready |-> $past(i_psel && i_penable))
      else $error("PREADY raised without an access cycle before it");

   // Single-cycle PREADY
   a_pready_one_cycle: assert property (
      @(posedge clk) disable iff (!i_rst_n)
      i_pready |=> !i_pready)
      else $error("PREADY held high for two cycles");

   // ----------------------------------------------------------------------
   // Reset value
   // ----------------------------------------------------------------------
   a_clock_ctrl_reset: assert property (
      @(posedge clk)
      !i_rst_n |=> (i_clock_control == `CLOCK_CTRL_RESET))
      else $error("clock control not at its reset value after reset");

endmodule

bind bus_int_top bus_int_chk u_chk (
   .clk             (clk),
   .i_rst_n         (i_rst_n),
   .i_psel          (i_psel),
   .i_penable       (i_penable),
   .i_pready        (o_pready),
   .i_clock_control (o_clock_control)
);

/* test/tb_bus_int.sv */
/*
 * Testbench for the board control bus top
 * APB transfers checked against a register and pin model
 */
`timescale 1ns/1ns
`include "bus_int_consts.svh"

module tb_bus_int
   import bus_types_pkg::*;
   import apb_pkg::*;
();

   localparam int          TIMEOUT_CYCLES = 3000;
   localparam logic [31:0] SEED           = 32'd21;
   localparam int          WRITE_ROUNDS   = 4;

   logic                        clk;
   logic                        rst_n;
   logic                        psel;
   logic                        penable;
   logic                        pwrite;
   apb_addr_t                   paddr;
   set_data_t                   pwdata;
   set_data_t                   prdata;
   logic                        pready;
   logic [4:0]                  clock_status;
   logic [7:0]                  leds;
   logic [3:0]                  sw_rst;
   logic [6:0]                  clock_control;
   logic [`NUM_SFPP-1:0][1:0]   rs_oe;
   sfpp_pins_t  [`NUM_SFPP-1:0] sfpp_pins;
   phy_status_t [`NUM_SFPP-1:0] phy_status;

   // Expected register state
   logic [7:0]                  leds_m;
   logic [3:0]                  sw_rst_m;
   logic [6:0]                  clk_ctrl_m;
   logic [`NUM_SFPP-1:0][1:0]   rs_m;
   sfpp_pins_t  [`NUM_SFPP-1:0] flags_m;

   logic [31:0] rng;
   int          cycle_cnt = 0;
   logic [31:0] cycles_since_rst = '0;
   // Pending comparisons
   // Filled at negedge and drained at posedge
   set_data_t   got_q[$];
   set_data_t   exp_q[$];
   string       what_q[$];

   bus_int_top u_dut (
      .clk             (clk),
      .i_rst_n         (rst_n),
      .i_psel          (psel),
      .i_penable       (penable),
      .i_pwrite        (pwrite),
      .i_paddr         (paddr),
      .i_pwdata        (pwdata),
      .o_prdata        (prdata),
      .o_pready        (pready),
      .i_clock_status  (clock_status),
      .o_leds          (leds),
      .o_sw_rst        (sw_rst),
      .o_clock_control (clock_control),
      .o_sfpp_rs_oe    (rs_oe),
      .i_sfpp_pins     (sfpp_pins),
      .i_phy_status    (phy_status)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // Cycle counting and timeout
   // ----------------------------------------------------------------------
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Simulation ran %0d cycles without finishing", cycle_cnt);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   // Clock edges since reset release
   // Tracks the DUT counter
   always @(posedge clk) begin
      if (rst_n) begin
         cycles_since_rst <= cycles_since_rst + 32'd1;
      end else begin
         cycles_since_rst <= '0;
      end
   end

   // ----------------------------------------------------------------------
   // Model and helpers
   // ----------------------------------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Expected word at the capture edge of a read
   function automatic set_data_t ref_readback(input set_addr_t addr);
      set_data_t word;
      word = '0;
      case (addr)
         // Counter value before the capture edge
         `RB_COUNTER:      word = cycles_since_rst - 32'd1;
         `RB_CLK_STATUS:   word = {27'b0, clock_status};
         `RB_COMPAT_NUM:   word = {`COMPAT_MAJOR, `COMPAT_MINOR};
         `RB_SFPP_STATUS0: word = {phy_status[0], 10'b0, flags_m[0], sfpp_pins[0]};
         `RB_SFPP_STATUS1: word = {phy_status[1], 10'b0, flags_m[1], sfpp_pins[1]};
         default:          word = '0;
      endcase
      return word;
   endfunction

   function automatic void apply_setting(input set_addr_t addr, input set_data_t data);
      case (addr)
         `SR_LEDS:       leds_m = data[7:0];
         `SR_SW_RST:     sw_rst_m = data[3:0];
         `SR_CLOCK_CTRL: clk_ctrl_m = data[6:0];
         `SR_SFPP_CTRL0: rs_m[0] = data[1:0];
         `SR_SFPP_CTRL1: rs_m[1] = data[1:0];
         default: ;
      endcase
   endfunction

   function automatic set_data_t outputs_now();
      return {9'b0, leds, sw_rst, clock_control, rs_oe};
   endfunction

   function automatic set_data_t outputs_model();
      return {9'b0, leds_m, sw_rst_m, clk_ctrl_m, rs_m};
   endfunction

   task automatic compare_values(input set_data_t got, input set_data_t exp,
                                 input string what);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic queue_compare(input set_data_t got, input set_data_t exp,
                                input string what);
      got_q.push_back(got);
      exp_q.push_back(exp);
      what_q.push_back(what);
   endtask

   // Comparing process
   always @(posedge clk) begin
      while (exp_q.size() > 0) begin
         compare_values(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
      end
   end

   // ----------------------------------------------------------------------
   // APB master tasks
   // ----------------------------------------------------------------------
   task automatic wait_ready();
      do @(negedge clk); while (!pready);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         psel    = 1'b0;
         penable = 1'b0;
      end
   endtask

   // Outputs compared in the PREADY cycle
   // Written register already updated by then
   task automatic apb_write(input set_addr_t addr, input set_data_t data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = {addr, 2'b00};
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      wait_ready();
      queue_compare(outputs_now(), outputs_model(), $sformatf("outputs after write %0d", addr));
      @(posedge clk);
   endtask

   task automatic apb_read(input set_addr_t addr, output set_data_t data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = {addr, 2'b00};
      @(negedge clk);
      penable = 1'b1;
      wait_ready();
      data = prdata;
      queue_compare(data, ref_readback(addr), $sformatf("readback %0d", addr));
      // Status read clears that port's flags
      if (addr == `RB_SFPP_STATUS0) flags_m[0] = '0;
      if (addr == `RB_SFPP_STATUS1) flags_m[1] = '0;
      @(posedge clk);
   endtask

   // ----------------------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------------------
   initial begin
      set_addr_t set_list [5];
      set_addr_t stat_addr [`NUM_SFPP];
      set_data_t data;
      set_data_t c0;
      set_data_t c1;
      int        bit_sel;
      set_list  = '{`SR_LEDS, `SR_SW_RST, `SR_CLOCK_CTRL, `SR_SFPP_CTRL0, `SR_SFPP_CTRL1};
      stat_addr = '{`RB_SFPP_STATUS0, `RB_SFPP_STATUS1};
      rng           = SEED;
      psel          = 1'b0;
      penable       = 1'b0;
      pwrite        = 1'b0;
      paddr         = '0;
      pwdata        = '0;
      clock_status  = '0;
      rng           = xorshift(rng);
      sfpp_pins[0]  = rng[2:0];
      sfpp_pins[1]  = rng[5:3];
      phy_status[0] = rng[31:16];
      phy_status[1] = rng[21:6];
      leds_m        = '0;
      sw_rst_m      = '0;
      clk_ctrl_m    = `CLOCK_CTRL_RESET;
      rs_m          = '0;
      flags_m       = '0;
      rst_n         = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Reset values on the outputs
      queue_compare(outputs_now(), outputs_model(), "outputs after reset");

      // Random writes to every settings address
      for (int r = 0; r < WRITE_ROUNDS; r++) begin
         foreach (set_list[i]) begin
            rng = xorshift(rng);
            apply_setting(set_list[i], rng);
            apb_write(set_list[i], rng);
         end
      end
      idle_cycles(2);

      // Identity, clock status and unmapped reads
      rng = xorshift(rng);
      clock_status = rng[4:0];
      apb_read(`RB_COMPAT_NUM, data);
      queue_compare(data, 32'h000A0000, "compat word");
      apb_read(`RB_CLK_STATUS, data);
      apb_read(8'd7, data);
      apb_read(8'd200, data);

      // Back-to-back counter reads one transfer apart
      apb_read(`RB_COUNTER, c0);
      apb_read(`RB_COUNTER, c1);
      queue_compare(c1 - c0, 32'd3, "counter step");
      idle_cycles(2);

      // One pin toggle plus PHY bits per port and two reads
      for (int p = 0; p < `NUM_SFPP; p++) begin
         rng     = xorshift(rng);
         bit_sel = int'(rng % 32'd3);
         sfpp_pins[p][bit_sel] = ~sfpp_pins[p][bit_sel];
         phy_status[p]         = phy_status[p] ^ (rng[31:16] | 16'h0001);
         flags_m[p][bit_sel]   = 1'b1;
         idle_cycles(6);
         apb_read(stat_addr[p], data);
         apb_read(stat_addr[p], data);
         apb_read(stat_addr[1-p], data);
         idle_cycles(1);
      end

      idle_cycles(2);
      while (exp_q.size() != 0) @(negedge clk);
      $display("TEST OK");
      $finish;
   end

endmodule
